//--- cpu_pkg.sv
package cpu_pkg;

    // ********************
    // Widths
    // ********************
    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int tag_width = 4;
    localparam int reg_sel_width = 5;
    localparam int alu_op_width = 4;

    // Reservation station sizing
    localparam int rs_depth = 4;
    localparam int rs_idx_width = $clog2(rs_depth);

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;
    typedef logic [rs_idx_width-1:0] rs_idx_t;

    // Number of younger entries still held
    typedef logic [rs_idx_width-1:0] age_t;

    // Operand holds a value, or the bus carries nothing
    localparam tag_t tag_free = '0;

    // Link offset for JAL and JALR
    localparam data_t link_offset = 32'd4;

    // ********************
    // ALU operations
    // ********************
    typedef enum logic [alu_op_width-1:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_sll   = 4'd2,
        op_slt   = 4'd3,
        op_sltu  = 4'd4,
        op_xor   = 4'd5,
        op_srl   = 4'd6,
        op_sra   = 4'd7,
        op_or    = 4'd8,
        op_and   = 4'd9,
        op_lui   = 4'd10,
        op_jal   = 4'd11,
        op_jalr  = 4'd12,
        op_auipc = 4'd13
    } alu_op_t;

endpackage

//--- ex_alu.sv
module ex_alu (
    // From rs_alu
    input  logic              ex_alu_en,
    input  cpu_pkg::data_t    exsrc1,
    input  cpu_pkg::data_t    exsrc2,
    input  cpu_pkg::addr_t    expc,
    input  cpu_pkg::alu_op_t  exaluop,
    input  cpu_pkg::tag_t     exdest,
    input  cpu_pkg::reg_sel_t exreg,
    // To the CDB arbiter
    output logic              en_rst,
    output cpu_pkg::data_t    rst_data,
    output cpu_pkg::tag_t     rst_tag,
    output cpu_pkg::reg_sel_t rst_reg,
    // Redirect
    output logic              jump_dest_valid,
    output cpu_pkg::addr_t    jump_dest
);
    import cpu_pkg::*;

    always_comb begin
        en_rst = 1'b0;
        rst_data = '0;
        rst_tag = tag_free;
        rst_reg = '0;
        jump_dest_valid = 1'b0;
        jump_dest = '0;
        if (ex_alu_en) begin
            en_rst = 1'b1;
            rst_tag = exdest;
            rst_reg = exreg;
            case (exaluop)
                op_add: rst_data = exsrc1 + exsrc2;
                op_sub: rst_data = exsrc1 - exsrc2;
                op_sll: rst_data = exsrc1 << exsrc2[4:0];
                op_slt: begin
                    rst_data = ($signed(exsrc1) < $signed(exsrc2)) ? 32'd1 : 32'd0;
                end
                op_sltu: begin
                    rst_data = (exsrc1 < exsrc2) ? 32'd1 : 32'd0;
                end
                op_xor: rst_data = exsrc1 ^ exsrc2;
                op_srl: rst_data = exsrc1 >> exsrc2[4:0];
                op_sra: rst_data = $signed(exsrc1) >>> exsrc2[4:0];
                op_or: rst_data = exsrc1 | exsrc2;
                op_and: rst_data = exsrc1 & exsrc2;
                op_lui: rst_data = exsrc2;
                // Target from src1 and src2, link from src2
                op_jal: begin
                    jump_dest = exsrc1 + exsrc2;
                    rst_data = exsrc2 + link_offset;
                    jump_dest_valid = 1'b1;
                end
                op_jalr: begin
                    jump_dest = (exsrc1 + exsrc2) & 32'hffff_fffe;
                    rst_data = expc + link_offset;
                    jump_dest_valid = 1'b1;
                end
                op_auipc: rst_data = exsrc1 + exsrc2;
                default: begin
                    rst_data = '0;
                end
            endcase
        end
    end

endmodule

//--- rs_alu.sv
module rs_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  cpu_pkg::alu_op_t  dispatch_op,
    input  cpu_pkg::tag_t     dispatch_src1_tag,
    input  cpu_pkg::tag_t     dispatch_src2_tag,
    input  cpu_pkg::data_t    dispatch_src1,
    input  cpu_pkg::data_t    dispatch_src2,
    input  cpu_pkg::addr_t    dispatch_pc,
    input  cpu_pkg::tag_t     dispatch_dest,
    input  cpu_pkg::reg_sel_t dispatch_reg,
    input  logic              cdb_valid,
    input  cpu_pkg::tag_t     cdb_tag,
    input  cpu_pkg::data_t    cdb_data,
    input  logic              alu_grant,
    output logic              ex_alu_en,
    output cpu_pkg::data_t    exsrc1,
    output cpu_pkg::data_t    exsrc2,
    output cpu_pkg::addr_t    expc,
    output cpu_pkg::alu_op_t  exaluop,
    output cpu_pkg::tag_t     exdest,
    output cpu_pkg::reg_sel_t exreg
);
    import cpu_pkg::*;

    logic     busy [rs_depth];
    age_t     age [rs_depth];
    alu_op_t  op_q [rs_depth];
    tag_t     src1_tag_q [rs_depth];
    tag_t     src2_tag_q [rs_depth];
    data_t    src1_q [rs_depth];
    data_t    src2_q [rs_depth];
    addr_t    pc_q [rs_depth];
    tag_t     dest_q [rs_depth];
    reg_sel_t reg_q [rs_depth];

    logic     entry_ready [rs_depth];
    logic     wake1 [rs_depth];
    logic     wake2 [rs_depth];
    logic     older [rs_depth];

    rs_idx_t  free_idx;
    rs_idx_t  issue_idx;
    age_t     best_age;
    logic     dispatch_fire;
    logic     issue_fire;
    logic     disp_hit1;
    logic     disp_hit2;

    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign issue_fire = ex_alu_en && alu_grant;

    // Operands woken by the broadcast in the dispatch cycle
    assign disp_hit1 = cdb_valid && (dispatch_src1_tag != tag_free) &&
                       (dispatch_src1_tag == cdb_tag);
    assign disp_hit2 = cdb_valid && (dispatch_src2_tag != tag_free) &&
                       (dispatch_src2_tag == cdb_tag);

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            wake1[i] = cdb_valid && (src1_tag_q[i] != tag_free) && (src1_tag_q[i] == cdb_tag);
            wake2[i] = cdb_valid && (src2_tag_q[i] != tag_free) && (src2_tag_q[i] == cdb_tag);
            entry_ready[i] = busy[i] && (src1_tag_q[i] == tag_free) &&
                             (src2_tag_q[i] == tag_free);
            older[i] = issue_fire && busy[i] && (age[i] > age[issue_idx]);
        end
    end

    // Lowest free slot
    always_comb begin
        dispatch_ready = 1'b0;
        free_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                dispatch_ready = 1'b1;
                free_idx = rs_idx_t'(i);
            end
        end
    end

    // ********************
    // Oldest ready entry
    // ********************
    always_comb begin
        ex_alu_en = 1'b0;
        issue_idx = '0;
        best_age = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (entry_ready[i] && (!ex_alu_en || age[i] > best_age)) begin
                ex_alu_en = 1'b1;
                issue_idx = rs_idx_t'(i);
                best_age = age[i];
            end
        end
    end

    assign exsrc1 = src1_q[issue_idx];
    assign exsrc2 = src2_q[issue_idx];
    assign expc = pc_q[issue_idx];
    assign exaluop = op_q[issue_idx];
    assign exdest = dest_q[issue_idx];
    assign exreg = reg_q[issue_idx];

    // Occupancy and relative age
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rs_depth; i++) begin
                busy[i] <= 1'b0;
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (issue_fire && issue_idx == rs_idx_t'(i)) begin
                    busy[i] <= 1'b0;
                    age[i] <= '0;
                end else if (busy[i]) begin
                    if (dispatch_fire && !older[i]) begin
                        age[i] <= age[i] + 1'b1;
                    end else if (!dispatch_fire && older[i]) begin
                        age[i] <= age[i] - 1'b1;
                    end
                end
            end
            if (dispatch_fire) begin
                busy[free_idx] <= 1'b1;
                age[free_idx] <= '0;
            end
        end
    end

    // Entry fields and CDB wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (dispatch_fire && free_idx == rs_idx_t'(i)) begin
                op_q[i] <= dispatch_op;
                src1_tag_q[i] <= disp_hit1 ? tag_free : dispatch_src1_tag;
                src2_tag_q[i] <= disp_hit2 ? tag_free : dispatch_src2_tag;
                src1_q[i] <= disp_hit1 ? cdb_data : dispatch_src1;
                src2_q[i] <= disp_hit2 ? cdb_data : dispatch_src2;
                pc_q[i] <= dispatch_pc;
                dest_q[i] <= dispatch_dest;
                reg_q[i] <= dispatch_reg;
            end else begin
                if (wake1[i]) begin
                    src1_q[i] <= cdb_data;
                    src1_tag_q[i] <= tag_free;
                end
                if (wake2[i]) begin
                    src2_q[i] <= cdb_data;
                    src2_tag_q[i] <= tag_free;
                end
            end
        end
    end

endmodule

//--- cdb_arbiter.sv
module cdb_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en_rst,
    input  cpu_pkg::data_t    rst_data,
    input  cpu_pkg::tag_t     rst_tag,
    input  cpu_pkg::reg_sel_t rst_reg,
    input  logic              jump_dest_valid,
    input  cpu_pkg::addr_t    jump_dest,
    output logic              alu_grant,
    input  logic              ext_valid,
    output logic              ext_ready,
    input  cpu_pkg::tag_t     ext_tag,
    input  cpu_pkg::data_t    ext_data,
    input  cpu_pkg::reg_sel_t ext_reg,
    output logic              cdb_valid,
    output cpu_pkg::tag_t     cdb_tag,
    output cpu_pkg::data_t    cdb_data,
    output cpu_pkg::reg_sel_t cdb_reg,
    output logic              jump_valid,
    output cpu_pkg::addr_t    jump_dest_out
);
    import cpu_pkg::*;

    // High when the external side wins the next contest
    logic ext_turn;
    logic ext_grant;

    assign alu_grant = en_rst && !(ext_valid && ext_turn);
    assign ext_grant = ext_valid && (!en_rst || ext_turn);
    assign ext_ready = ext_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_turn <= 1'b0;
            cdb_valid <= 1'b0;
            jump_valid <= 1'b0;
            cdb_tag <= tag_free;
        end else begin
            cdb_valid <= alu_grant || ext_grant;
            jump_valid <= alu_grant && jump_dest_valid;
            if (alu_grant) begin
                ext_turn <= 1'b1;
                cdb_tag <= rst_tag;
            end else if (ext_grant) begin
                ext_turn <= 1'b0;
                cdb_tag <= ext_tag;
            end else begin
                cdb_tag <= tag_free;
            end
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (alu_grant) begin
            cdb_data <= rst_data;
            cdb_reg <= rst_reg;
            jump_dest_out <= jump_dest;
        end else if (ext_grant) begin
            cdb_data <= ext_data;
            cdb_reg <= ext_reg;
        end
    end

endmodule

//--- alu_cluster.sv
module alu_cluster (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  cpu_pkg::alu_op_t  dispatch_op,
    input  cpu_pkg::tag_t     dispatch_src1_tag,
    input  cpu_pkg::tag_t     dispatch_src2_tag,
    input  cpu_pkg::data_t    dispatch_src1,
    input  cpu_pkg::data_t    dispatch_src2,
    input  cpu_pkg::addr_t    dispatch_pc,
    input  cpu_pkg::tag_t     dispatch_dest,
    input  cpu_pkg::reg_sel_t dispatch_reg,
    input  logic              ext_valid,
    output logic              ext_ready,
    input  cpu_pkg::tag_t     ext_tag,
    input  cpu_pkg::data_t    ext_data,
    input  cpu_pkg::reg_sel_t ext_reg,
    output logic              cdb_valid,
    output cpu_pkg::tag_t     cdb_tag,
    output cpu_pkg::data_t    cdb_data,
    output cpu_pkg::reg_sel_t cdb_reg,
    output logic              jump_valid,
    output cpu_pkg::addr_t    jump_dest
);
    import cpu_pkg::*;

    // Issue path into ex_alu
    logic     ex_alu_en;
    data_t    exsrc1;
    data_t    exsrc2;
    addr_t    expc;
    alu_op_t  exaluop;
    tag_t     exdest;
    reg_sel_t exreg;

    // ALU result request
    logic     alu_grant;
    logic     en_rst;
    data_t    rst_data;
    tag_t     rst_tag;
    reg_sel_t rst_reg;
    logic     jump_dest_valid;
    addr_t    alu_jump_dest;

    // CDB feeds back into the station for wakeup
    rs_alu i_rs_alu (.*);

    ex_alu i_ex_alu (
        .*,
        .jump_dest (alu_jump_dest)
    );

    cdb_arbiter i_cdb_arbiter (
        .*,
        .jump_dest     (alu_jump_dest),
        .jump_dest_out (jump_dest)
    );

endmodule

//--- tb_checker.sv
module tb_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dispatch_valid,
    input  logic              ext_valid,
    input  logic              cdb_valid,
    input  cpu_pkg::tag_t     cdb_tag,
    input  cpu_pkg::data_t    cdb_data,
    input  cpu_pkg::reg_sel_t cdb_reg,
    input  logic              jump_valid,
    input  cpu_pkg::addr_t    jump_dest,
    input  int                num_lines,
    input  logic [127:0]      line_name [32],
    input  cpu_pkg::tag_t     line_dest [32],
    input  cpu_pkg::data_t    line_exp [32],
    input  cpu_pkg::reg_sel_t line_reg [32],
    input  logic              line_jmp [32],
    input  cpu_pkg::addr_t    line_jdest [32],
    input  logic              run_done,
    output int                error_count,
    output logic              all_seen
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int max_lines = 32;

    logic seen [max_lines];
    logic input_seen;
    logic report_done;
    int   matched;

    assign all_seen = (matched == num_lines);

    // First dispatch or external result
    always @(posedge clk) begin
        if (!rst_n) begin
            input_seen <= 1'b0;
        end else if (dispatch_valid || ext_valid) begin
            input_seen <= 1'b1;
        end
    end

    // ********************
    // Compare on the falling edge
    // ********************
    always @(negedge clk) begin
        int idx;
        if (!rst_n) begin
            for (int i = 0; i < max_lines; i++) begin
                seen[i] = 1'b0;
            end
            matched = 0;
            error_count = 0;
            report_done = 1'b0;
        end else begin
            // Bus must stay quiet until the first input arrives
            if (!input_seen && (cdb_valid || jump_valid)) begin
                $display("CDB became active before any dispatch or external result");
                error_count++;
            end
            if (cdb_valid) begin
                idx = -1;
                for (int i = 0; i < num_lines; i++) begin
                    if (idx < 0 && !seen[i] && line_dest[i] == cdb_tag) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    $display("broadcast of tag %0d matches no outstanding result", cdb_tag);
                    error_count++;
                end else begin
                    seen[idx] = 1'b1;
                    matched++;
                    if (cdb_data !== line_exp[idx]) begin
                        $display("Fail %0s data expected %h actual %h",
                                 line_name[idx], line_exp[idx], cdb_data);
                        error_count++;
                    end
                    if (cdb_reg !== line_reg[idx]) begin
                        $display("Fail %0s reg expected %h actual %h",
                                 line_name[idx], line_reg[idx], cdb_reg);
                        error_count++;
                    end
                    if (line_jmp[idx] && !jump_valid) begin
                        $display("%0s broadcast without its jump redirect", line_name[idx]);
                        error_count++;
                    end else if (line_jmp[idx] && jump_dest !== line_jdest[idx]) begin
                        $display("Fail %0s jump_dest expected %h actual %h",
                                 line_name[idx], line_jdest[idx], jump_dest);
                        error_count++;
                    end else if (!line_jmp[idx] && jump_valid) begin
                        $display("%0s raised a jump redirect it should not", line_name[idx]);
                        error_count++;
                    end
                end
            end else if (jump_valid) begin
                $display("jump_valid raised without a CDB broadcast");
                error_count++;
            end
            // Results that never showed up
            if (run_done && !report_done) begin
                report_done = 1'b1;
                for (int i = 0; i < num_lines; i++) begin
                    if (!seen[i]) begin
                        $display("tag %0d of %0s was never broadcast", line_dest[i],
                                 line_name[i]);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

//--- tb_alu_cluster.sv
module tb_alu_cluster;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int max_lines = 32;

    logic     clk;
    logic     rst_n;
    logic     dispatch_valid;
    logic     dispatch_ready;
    alu_op_t  dispatch_op;
    tag_t     dispatch_src1_tag;
    tag_t     dispatch_src2_tag;
    data_t    dispatch_src1;
    data_t    dispatch_src2;
    addr_t    dispatch_pc;
    tag_t     dispatch_dest;
    reg_sel_t dispatch_reg;
    logic     ext_valid;
    logic     ext_ready;
    tag_t     ext_tag;
    data_t    ext_data;
    reg_sel_t ext_reg;
    logic     cdb_valid;
    tag_t     cdb_tag;
    data_t    cdb_data;
    reg_sel_t cdb_reg;
    logic     jump_valid;
    addr_t    jump_dest;

    // ********************
    // Vector table
    // ********************
    logic         is_ext [max_lines];
    logic [127:0] line_name [max_lines];
    alu_op_t      line_op [max_lines];
    tag_t         line_tag1 [max_lines];
    tag_t         line_tag2 [max_lines];
    data_t        line_src1 [max_lines];
    data_t        line_src2 [max_lines];
    addr_t        line_pc [max_lines];
    tag_t         line_dest [max_lines];
    reg_sel_t     line_reg [max_lines];
    int           line_gap [max_lines];
    logic         line_jmp [max_lines];
    data_t        line_exp [max_lines];
    addr_t        line_jdest [max_lines];
    int           line_dbefore [max_lines];

    int   num_lines;
    int   accepted;
    int   seed_val;
    int   error_count;
    logic loaded;
    logic run_done;
    logic all_seen;

    alu_cluster i_dut (.*);

    tb_checker i_checker (.*);

    always #50 clk = ~clk;

    task automatic load_vectors(output logic ok);
        int           fd;
        int           n;
        int           d_count;
        string        text;
        logic [7:0]   kind;
        logic [127:0] name;
        logic [3:0]   op;
        logic [3:0]   t1;
        logic [3:0]   t2;
        logic [3:0]   dest;
        logic [3:0]   gap;
        logic [4:0]   rg;
        logic [31:0]  s1;
        logic [31:0]  s2;
        logic [31:0]  pc;
        logic [31:0]  expv;
        logic [31:0]  jd;
        logic         jmp;
        ok = 1'b0;
        num_lines = 0;
        d_count = 0;
        fd = $fopen("alu_cluster_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h",
                                kind, name, op, t1, t2, s1, s2, pc, dest, rg, gap, jmp,
                                expv, jd);
                    if (n == 14 && num_lines < max_lines) begin
                        is_ext[num_lines] = (kind == "E");
                        line_name[num_lines] = name;
                        line_op[num_lines] = alu_op_t'(op);
                        line_tag1[num_lines] = t1;
                        line_tag2[num_lines] = t2;
                        line_src1[num_lines] = s1;
                        line_src2[num_lines] = s2;
                        line_pc[num_lines] = pc;
                        line_dest[num_lines] = dest;
                        line_reg[num_lines] = rg;
                        line_gap[num_lines] = int'(gap);
                        line_jmp[num_lines] = jmp;
                        line_exp[num_lines] = expv;
                        line_jdest[num_lines] = jd;
                        line_dbefore[num_lines] = d_count;
                        if (kind != "E") begin
                            d_count++;
                        end
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_dispatch_line(input int i);
        logic got;
        dispatch_valid = 1'b1;
        dispatch_op = line_op[i];
        dispatch_src1_tag = line_tag1[i];
        dispatch_src2_tag = line_tag2[i];
        dispatch_src1 = line_src1[i];
        dispatch_src2 = line_src2[i];
        dispatch_pc = line_pc[i];
        dispatch_dest = line_dest[i];
        dispatch_reg = line_reg[i];
        do begin
            #10;
            got = dispatch_ready;
            if (!got) begin
                @(negedge clk);
            end
        end while (!got);
        @(posedge clk);
        accepted++;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drive_ext_line(input int i);
        logic got;
        ext_valid = 1'b1;
        ext_tag = line_dest[i];
        ext_data = line_src1[i];
        ext_reg = line_reg[i];
        do begin
            #10;
            got = ext_ready;
            if (!got) begin
                @(negedge clk);
            end
        end while (!got);
        @(posedge clk);
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    task automatic run_dispatches();
        int g;
        for (int i = 0; i < num_lines; i++) begin
            if (!is_ext[i]) begin
                g = (line_gap[i] == 15) ? int'($urandom % 3) : line_gap[i];
                repeat (g) @(negedge clk);
                drive_dispatch_line(i);
            end
        end
    endtask

    // An external result waits for every dispatch listed before it
    task automatic run_ext_results();
        for (int i = 0; i < num_lines; i++) begin
            if (is_ext[i]) begin
                wait (accepted >= line_dbefore[i]);
                @(negedge clk);
                drive_ext_line(i);
            end
        end
    endtask

    initial begin
        logic ok;
        seed_val = $urandom(32'h0620_b190);
        clk = 1'b0;
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_src1_tag = tag_free;
        dispatch_src2_tag = tag_free;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_pc = '0;
        dispatch_dest = tag_free;
        dispatch_reg = '0;
        ext_valid = 1'b0;
        ext_tag = tag_free;
        ext_data = '0;
        ext_reg = '0;
        accepted = 0;
        loaded = 1'b0;
        run_done = 1'b0;
        load_vectors(ok);
        if (!ok) begin
            $display("could not open alu_cluster_vectors.txt");
            $display("Regression failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            // Idle cycles for the quiet bus check
            repeat (3) @(negedge clk);
            fork
                run_dispatches();
                run_ext_results();
            join
            wait (all_seen);
            repeat (4) @(negedge clk);
            run_done = 1'b1;
            repeat (2) @(posedge clk);
            $display("errors: %0d", error_count);
            if (error_count == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

    // ********************
    // Watchdog
    // ********************
    initial begin
        wait (loaded);
        repeat (num_lines * 20 + 50) @(posedge clk);
        $display("timeout: results still missing after the time limit");
        run_done = 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: %0d", error_count);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- alu_cluster.f
cpu_pkg.sv
ex_alu.sv
rs_alu.sv
cdb_arbiter.sv
alu_cluster.sv
tb_checker.sv
tb_alu_cluster.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f alu_cluster.f --top-module tb_alu_cluster \
    -o sim_alu_cluster && \
    ./obj_dir/sim_alu_cluster | tee /dev/stderr | grep -q "Regression passed" && \
    echo "simulation ok" || { echo "simulation reported errors"; exit 1; }

//--- alu_cluster_vectors.txt
# kind name op src1_tag src2_tag src1 src2 pc dest reg gap jump expected jump_dest
# kind D is a dispatch, E an external result (tag in dest, data in src1), gap f is random
D add_value 0 0 0 00000005 00000007 00000000 1 01 0 0 0000000c 00000000
D add_same_cycle 0 1 0 00000000 00000003 00000000 2 02 1 0 0000000f 00000000
D sub_value 1 0 0 0000000a 00000003 00000000 3 03 f 0 00000007 00000000
D sll_value 2 0 0 00000001 00000024 00000000 4 04 f 0 00000010 00000000
D slt_value 3 0 0 ffffffff 00000001 00000000 5 05 f 0 00000001 00000000
D sltu_value 4 0 0 ffffffff 00000001 00000000 6 06 f 0 00000000 00000000
D lui_value a 0 0 00000000 12345000 00000000 7 07 f 0 12345000 00000000
D jal_value b 0 0 00000100 00000020 00000000 8 08 f 1 00000024 00000120
D jalr_value c 0 0 00000200 00000007 00000040 9 09 f 1 00000044 00000206
D auipc_value d 0 0 00001000 00002000 00000000 a 0a f 0 00003000 00000000
D xor_chain 5 b 0 00000000 ff00ff00 00000000 c 0c 0 0 f00ff00f 00000000
D sra_chain 7 c 0 00000000 00000004 00000000 d 0d 0 0 ff00ff00 00000000
D srl_chain 6 d 0 00000000 00000008 00000000 e 0e 0 0 00ff00ff 00000000
D or_chain 8 e 0 00000000 f0000000 00000000 f 0f 0 0 f0ff00ff 00000000
E ext_chain_src 0 0 0 0f0f0f0f 00000000 00000000 b 0b 0 0 0f0f0f0f 00000000
D and_stalled 9 f 0 00000000 0000ffff 00000000 1 1f 0 0 000000ff 00000000
D add_contend 0 0 0 11111111 22222222 00000000 3 13 f 0 33333333 00000000
E ext_contend_a 0 0 0 44444444 00000000 00000000 4 14 0 0 44444444 00000000
E ext_contend_b 0 0 0 55555555 00000000 00000000 5 15 0 0 55555555 00000000
D sub_contend 1 0 0 00000064 00000001 00000000 6 16 0 0 00000063 00000000
